//--- hw/loader_pkg.sv
`default_nettype none

package loader_pkg;

   // serial line timing, clock cycles per bit
   localparam int bit_cycles = 6;
   localparam int cnt_bits = $clog2(bit_cycles);

   // last count of a whole bit
   localparam logic [cnt_bits-1:0] bit_last = cnt_bits'(bit_cycles - 1);
   // last count before the middle of the start bit
   localparam logic [cnt_bits-1:0] half_last = cnt_bits'(bit_cycles / 2 - 1);
   // stop bit tail, ends early enough to catch a start bit right behind it
   localparam logic [cnt_bits-1:0] tail_last = cnt_bits'(bit_cycles / 2 - 3);

   // sram geometry
   localparam int addr_bits = 20;
   localparam logic [addr_bits-1:0] sram_words = addr_bits'(256);

   // word that ends the load phase
   localparam logic [31:0] end_marker = 32'hffffffff;

   // loader states
   localparam logic [2:0] st_load = 3'd0;
   localparam logic [2:0] st_read = 3'd1;
   localparam logic [2:0] st_wait = 3'd2;
   localparam logic [2:0] st_send = 3'd3;
   localparam logic [2:0] st_echo = 3'd4;

   // one sram word, or four serial bytes with byte 3 sent first
   typedef union packed {
      logic [31:0]     word;
      logic [3:0][7:0] bytes;
   } sram_word_u;

endpackage

`default_nettype wire

//--- hw/uart_rx.sv
`default_nettype none

module uart_rx (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       rx,
   output logic [7:0] rx_data,
   output logic       changed
);

   logic                            rx_meta;
   logic                            rx_sync;
   logic                            active;
   logic [3:0]                      bit_idx;
   logic [loader_pkg::cnt_bits-1:0] cnt;
   logic [7:0]                      shift;
   logic                            sample_data;
   logic                            frame_done;

   // bit 0 is the start bit, 1 to 8 data, 9 stop, 10 the tail
   assign sample_data = active && bit_idx >= 4'd1 && bit_idx <= 4'd8 &&
                        cnt == loader_pkg::bit_last;
   assign frame_done  = active && bit_idx == 4'd10 && cnt == loader_pkg::tail_last;

   // two-flop synchronizer, idles high like the line
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         active  <= 1'b0;
         bit_idx <= '0;
         cnt     <= '0;
         changed <= 1'b0;
      end else begin
         changed <= 1'b0;
         if (!active) begin
            // falling line starts a frame
            if (!rx_sync) begin
               active  <= 1'b1;
               bit_idx <= '0;
               cnt     <= '0;
            end
         end else if (bit_idx == 4'd0) begin
            cnt <= cnt + 1'b1;
            if (cnt == loader_pkg::half_last) begin
               cnt <= '0;
               // glitch, line back high at mid start
               if (rx_sync) begin
                  active <= 1'b0;
               end else begin
                  bit_idx <= 4'd1;
               end
            end
         end else if (bit_idx == 4'd9) begin
            cnt <= cnt + 1'b1;
            if (cnt == loader_pkg::bit_last) begin
               cnt <= '0;
               // framing error drops the byte
               if (rx_sync) begin
                  bit_idx <= 4'd10;
               end else begin
                  active <= 1'b0;
               end
            end
         end else if (frame_done) begin
            active  <= 1'b0;
            changed <= 1'b1;
         end else begin
            cnt <= cnt + 1'b1;
            if (sample_data) begin
               cnt     <= '0;
               bit_idx <= bit_idx + 1'b1;
            end
         end
      end
   end

   // lsb arrives first
   always_ff @(posedge clk) begin
      if (sample_data) begin
         shift <= {rx_sync, shift[7:1]};
      end
      if (frame_done) begin
         rx_data <= shift;
      end
   end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`default_nettype none

module uart_tx (
   input  logic       clk,
   input  logic       arst_n,
   input  logic [7:0] tx_data,
   input  logic       start,
   output logic       tx,
   output logic       busy
);

   // data bits then the stop bit, shifted out from bit 0
   logic [8:0]                      shift;
   logic [3:0]                      bit_idx;
   logic [loader_pkg::cnt_bits-1:0] cnt;
   logic                            launch;
   logic                            bit_end;

   assign launch  = start && !busy;
   assign bit_end = busy && cnt == loader_pkg::bit_last;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx      <= 1'b1;
         busy    <= 1'b0;
         bit_idx <= '0;
         cnt     <= '0;
      end else if (launch) begin
         // start bit goes out right away
         tx      <= 1'b0;
         busy    <= 1'b1;
         bit_idx <= '0;
         cnt     <= '0;
      end else if (bit_end) begin
         cnt <= '0;
         if (bit_idx == 4'd9) begin
            // stop bit done, line already high
            busy <= 1'b0;
         end else begin
            tx      <= shift[0];
            bit_idx <= bit_idx + 1'b1;
         end
      end else if (busy) begin
         cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (launch) begin
         shift <= {1'b1, tx_data};
      end else if (bit_end) begin
         shift <= {1'b1, shift[8:1]};
      end
   end

endmodule

`default_nettype wire

//--- hw/sram_ctrl.sv
`default_nettype none

module sram_ctrl (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             mem_we,
   input  logic                             mem_re,
   input  logic [loader_pkg::addr_bits-1:0] mem_addr,
   input  loader_pkg::sram_word_u           mem_wdata,
   output loader_pkg::sram_word_u           mem_rdata,
   output logic                             mem_rvalid,
   inout  wire  [31:0]                      zd,
   output logic [loader_pkg::addr_bits-1:0] za,
   output logic                             xe1,
   output logic                             xga,
   output logic                             xwa,
   output logic [3:0]                       xzbe
);

   // pending accesses, stage 0 is the cycle the pins carry the address
   logic [1:0]             wr_pend;
   logic [1:0]             rd_pend;
   loader_pkg::sram_word_u wd_pend [2];
   // write data phase, two cycles after the address phase
   logic                   drive;
   loader_pkg::sram_word_u zd_out;

   assign zd = drive ? zd_out.word : 32'bz;

   // read data sits on zd in the same cycle as mem_rvalid
   assign mem_rdata = zd;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         xe1        <= 1'b1;
         xwa        <= 1'b1;
         xga        <= 1'b1;
         xzbe       <= 4'hf;
         wr_pend    <= '0;
         rd_pend    <= '0;
         drive      <= 1'b0;
         mem_rvalid <= 1'b0;
      end else begin
         // address phase
         xe1  <= !(mem_we || mem_re);
         xwa  <= !mem_we;
         xzbe <= {4{!mem_we}};

         wr_pend <= {wr_pend[0], mem_we};
         rd_pend <= {rd_pend[0], mem_re};

         // data phase
         drive      <= wr_pend[1];
         xga        <= !rd_pend[1];
         mem_rvalid <= rd_pend[1];
      end
   end

   always_ff @(posedge clk) begin
      if (mem_we || mem_re) begin
         za <= mem_addr;
      end
      wd_pend[0] <= mem_wdata;
      wd_pend[1] <= wd_pend[0];
      zd_out     <= wd_pend[1];
   end

endmodule

`default_nettype wire

//--- hw/loader.sv
`default_nettype none

module loader (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic [7:0]                       rx_data,
   input  logic                             changed,
   output logic [7:0]                       tx_data,
   output logic                             start,
   input  logic                             busy,
   output logic                             mem_we,
   output logic                             mem_re,
   output logic [loader_pkg::addr_bits-1:0] mem_addr,
   output loader_pkg::sram_word_u           mem_wdata,
   input  loader_pkg::sram_word_u           mem_rdata,
   input  logic                             mem_rvalid
);

   logic [2:0]                       state;
   logic [1:0]                       byte_idx;
   logic [loader_pkg::addr_bits-1:0] count;
   logic [loader_pkg::addr_bits-1:0] rd_addr;
   logic                             echo_pend;
   loader_pkg::sram_word_u           word_buf;
   loader_pkg::sram_word_u           word_next;
   logic                             send_ok;
   logic                             load_byte;
   logic                             load_last;
   logic                             store;
   logic                             send_byte;
   logic                             echo_take;

   // byte index 0 fills byte 3, msb first
   always_comb begin
      word_next = word_buf;
      word_next.bytes[~byte_idx] = rx_data;
   end

   // busy only rises the cycle after start
   assign send_ok   = !busy && !start;
   assign load_byte = state == loader_pkg::st_load && changed;
   assign load_last = load_byte && byte_idx == 2'd3;
   assign store     = load_last && word_next.word != loader_pkg::end_marker &&
                      count != loader_pkg::sram_words;
   assign send_byte = state == loader_pkg::st_send && send_ok;
   assign echo_take = state == loader_pkg::st_echo && changed;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= loader_pkg::st_load;
         byte_idx  <= '0;
         count     <= '0;
         rd_addr   <= '0;
         echo_pend <= 1'b0;
         start     <= 1'b0;
         mem_we    <= 1'b0;
         mem_re    <= 1'b0;
      end else begin
         start  <= 1'b0;
         mem_we <= store;
         mem_re <= 1'b0;
         case (state)
            loader_pkg::st_load: begin
               if (load_byte) begin
                  byte_idx <= byte_idx + 1'b1;
               end
               if (store) begin
                  count <= count + 1'b1;
               end
               if (load_last && word_next.word == loader_pkg::end_marker) begin
                  rd_addr <= '0;
                  state   <= (count == '0) ? loader_pkg::st_echo : loader_pkg::st_read;
               end
            end
            loader_pkg::st_read: begin
               mem_re <= 1'b1;
               state  <= loader_pkg::st_wait;
            end
            loader_pkg::st_wait: begin
               if (mem_rvalid) begin
                  byte_idx <= '0;
                  state    <= loader_pkg::st_send;
               end
            end
            loader_pkg::st_send: begin
               if (send_byte) begin
                  start    <= 1'b1;
                  byte_idx <= byte_idx + 1'b1;
                  if (byte_idx == 2'd3) begin
                     rd_addr <= rd_addr + 1'b1;
                     if (rd_addr + 1'b1 == count) begin
                        state <= loader_pkg::st_echo;
                     end else begin
                        state <= loader_pkg::st_read;
                     end
                  end
               end
            end
            loader_pkg::st_echo: begin
               // the last dump byte may still be on the line
               if (echo_take) begin
                  if (send_ok) begin
                     start <= 1'b1;
                  end else begin
                     echo_pend <= 1'b1;
                  end
               end else if (echo_pend && send_ok) begin
                  start     <= 1'b1;
                  echo_pend <= 1'b0;
               end
            end
            default: begin
               state <= loader_pkg::st_load;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load_byte) begin
         word_buf <= word_next;
      end else if (state == loader_pkg::st_wait && mem_rvalid) begin
         word_buf <= mem_rdata;
      end

      if (store) begin
         mem_wdata <= word_next;
         mem_addr  <= count;
      end else if (state == loader_pkg::st_read) begin
         mem_addr <= rd_addr;
      end

      if (send_byte) begin
         tx_data <= word_buf.bytes[~byte_idx];
      end else if (echo_take) begin
         tx_data <= rx_data;
      end
   end

endmodule

`default_nettype wire

//--- hw/top.sv
`default_nettype none

module top (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             rs_rx,
   output logic                             rs_tx,
   inout  wire  [31:0]                      zd,
   output logic [loader_pkg::addr_bits-1:0] za,
   output logic                             xe1,
   output logic                             xga,
   output logic                             xwa,
   output logic [3:0]                       xzbe
);

   // serial side
   logic [7:0]                       rx_data;
   logic                             changed;
   logic [7:0]                       tx_data;
   logic                             start;
   logic                             busy;

   // memory side
   logic                             mem_we;
   logic                             mem_re;
   logic [loader_pkg::addr_bits-1:0] mem_addr;
   loader_pkg::sram_word_u           mem_wdata;
   loader_pkg::sram_word_u           mem_rdata;
   logic                             mem_rvalid;

   uart_rx receiver (
      .clk     (clk),
      .arst_n  (arst_n),
      .rx      (rs_rx),
      .rx_data (rx_data),
      .changed (changed)
   );

   uart_tx transmitter (
      .clk     (clk),
      .arst_n  (arst_n),
      .tx_data (tx_data),
      .start   (start),
      .tx      (rs_tx),
      .busy    (busy)
   );

   loader ldr (
      .clk        (clk),
      .arst_n     (arst_n),
      .rx_data    (rx_data),
      .changed    (changed),
      .tx_data    (tx_data),
      .start      (start),
      .busy       (busy),
      .mem_we     (mem_we),
      .mem_re     (mem_re),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid)
   );

   sram_ctrl memctl (
      .clk        (clk),
      .arst_n     (arst_n),
      .mem_we     (mem_we),
      .mem_re     (mem_re),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .zd         (zd),
      .za         (za),
      .xe1        (xe1),
      .xga        (xga),
      .xwa        (xwa),
      .xzbe       (xzbe)
   );

endmodule

`default_nettype wire

//--- dv/fake_sram.sv
`default_nettype none

module fake_sram (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic [loader_pkg::addr_bits-1:0] za,
   input  logic                             xe1,
   input  logic                             xga,
   input  logic                             xwa,
   input  logic [3:0]                       xzbe,
   inout  wire  [31:0]                      zd
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0]                      mem [0:(1 << loader_pkg::addr_bits) - 1];
   // stage 0 is the cycle after the address was sampled
   logic [1:0]                       rd_v;
   logic [1:0]                       wr_v;
   logic [loader_pkg::addr_bits-1:0] a0;
   logic [loader_pkg::addr_bits-1:0] a1;
   logic [3:0]                       be0;
   logic [3:0]                       be1;
   logic [31:0]                      rdata;

   // read data two cycles after the address
   assign zd = (rd_v[1] && !xga) ? rdata : 32'bz;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_v <= '0;
         wr_v <= '0;
      end else begin
         rd_v <= {rd_v[0], !xe1 && xwa};
         wr_v <= {wr_v[0], !xe1 && !xwa};
      end
   end

   always_ff @(posedge clk) begin
      a0  <= za;
      a1  <= a0;
      be0 <= xzbe;
      be1 <= be0;
      if (rd_v[0]) begin
         rdata <= mem[a0];
      end
      // late write, data comes two cycles after the address
      if (wr_v[1]) begin
         for (int b = 0; b < 4; b++) begin
            if (!be1[b]) begin
               mem[a1][8*b +: 8] <= zd[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/top_assert.sv
`default_nettype none

module top_assert (
   input logic clk,
   input logic arst_n,
   input logic changed,
   input logic start,
   input logic busy,
   input logic mem_we,
   input logic mem_re
);

   timeunit 1ns;
   timeprecision 100ps;

   changed_pulse: assert property (@(posedge clk) disable iff (!arst_n) changed |=> !changed)
      else $error("changed stayed high for more than one cycle");

   start_pulse: assert property (@(posedge clk) disable iff (!arst_n) start |=> !start)
      else $error("start stayed high for more than one cycle");

   // transmitter must be free when a byte is launched
   start_idle: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
      else $error("start pulsed while the transmitter was busy");

   mem_excl: assert property (@(posedge clk) disable iff (!arst_n) !(mem_we && mem_re))
      else $error("memory write and read requested in the same cycle");

endmodule

bind top top_assert checks (
   .clk     (clk),
   .arst_n  (arst_n),
   .changed (changed),
   .start   (start),
   .busy    (busy),
   .mem_we  (mem_we),
   .mem_re  (mem_re)
);

`default_nettype wire

//--- dv/tb_top.sv
`default_nettype none

module tb_top;

   timeunit 1ns;
   timeprecision 100ps;

   logic                             clk;
   logic                             arst_n;
   logic                             rs_rx;
   logic                             rs_tx;
   wire  [31:0]                      zd;
   logic [loader_pkg::addr_bits-1:0] za;
   logic                             xe1;
   logic                             xga;
   logic                             xwa;
   logic [3:0]                       xzbe;

   integer                 seed;
   int                     errors;
   int                     checks;
   int                     cycles;
   int                     cycle_limit;
   int                     n_words;
   // expected transmit bytes, and the dumped words they form
   logic [7:0]             exp_bytes [$];
   loader_pkg::sram_word_u exp_words [$];
   int                     dump_left;
   int                     got_idx;
   loader_pkg::sram_word_u got_word;
   bit                     decoding;

   top UUT (
      .clk    (clk),
      .arst_n (arst_n),
      .rs_rx  (rs_rx),
      .rs_tx  (rs_tx),
      .zd     (zd),
      .za     (za),
      .xe1    (xe1),
      .xga    (xga),
      .xwa    (xwa),
      .xzbe   (xzbe)
   );

   fake_sram sram (
      .clk    (clk),
      .arst_n (arst_n),
      .za     (za),
      .xe1    (xe1),
      .xga    (xga),
      .xwa    (xwa),
      .xzbe   (xzbe),
      .zd     (zd)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout, run went past %0d cycles", cycle_limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_word(input string name, input loader_pkg::sram_word_u got,
                             input loader_pkg::sram_word_u exp);
      checks++;
      if (got.word !== exp.word) begin
         errors++;
         $display("ERROR %s: got %h, expected %h at %0t", name, got.word, exp.word, $time);
      end
   endtask

   task automatic check_frame(input logic stop_bit);
      checks++;
      if (stop_bit !== 1'b1) begin
         errors++;
         $display("ERROR rs_tx stop bit: got %h, expected %h at %0t", stop_bit, 1'b1, $time);
      end
   endtask

   // msb first, so the first dump byte lands in byte 3
   task automatic collect_dump(input logic [7:0] b);
      loader_pkg::sram_word_u w;
      if (dump_left > 0) begin
         got_word.bytes[3 - got_idx] = b;
         got_idx++;
         dump_left--;
         if (got_idx == 4) begin
            got_idx = 0;
            w = exp_words.pop_front();
            check_word("dumped word", got_word, w);
         end
      end
   endtask

   task automatic drive_bit(input logic v);
      rs_rx = v;
      repeat (loader_pkg::bit_cycles) @(negedge clk);
   endtask

   task automatic send_byte(input logic [7:0] b);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         drive_bit(b[i]);
      end
      drive_bit(1'b1);
   endtask

   task automatic send_word(input loader_pkg::sram_word_u w);
      for (int i = 3; i >= 0; i--) begin
         send_byte(w.bytes[i]);
      end
   endtask

   function automatic logic [7:0] random_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic loader_pkg::sram_word_u random_word();
      loader_pkg::sram_word_u w;
      do begin
         w.word = $random(seed);
      end while (w.word == loader_pkg::end_marker);
      return w;
   endfunction

   task automatic apply_reset();
      @(negedge clk);
      arst_n = 1'b0;
      rs_rx  = 1'b1;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic wait_drained();
      while (exp_bytes.size() != 0 || decoding) begin
         @(negedge clk);
      end
   endtask

   // samples rs_tx near mid-bit, any frame with nothing queued is an error
   initial begin : tx_decoder
      logic [7:0] rx_byte;
      logic [7:0] exp_byte;
      decoding = 1'b0;
      forever begin
         @(negedge clk);
         if (arst_n === 1'b1 && rs_tx !== 1'b1) begin
            decoding = 1'b1;
            if (exp_bytes.size() == 0) begin
               errors++;
               $display("rs_tx left idle with no byte expected at %0t", $time);
            end
            repeat (loader_pkg::bit_cycles / 2 - 1) @(negedge clk);
            if (rs_tx !== 1'b0) begin
               errors++;
               $display("start bit on rs_tx was too short at %0t", $time);
            end
            for (int i = 0; i < 8; i++) begin
               repeat (loader_pkg::bit_cycles) @(negedge clk);
               rx_byte[i] = rs_tx;
            end
            repeat (loader_pkg::bit_cycles) @(negedge clk);
            check_frame(rs_tx);
            if (exp_bytes.size() != 0) begin
               exp_byte = exp_bytes.pop_front();
               check_byte("rs_tx byte", rx_byte, exp_byte);
               collect_dump(rx_byte);
            end
            decoding = 1'b0;
         end
      end
   end

   initial begin : main
      loader_pkg::sram_word_u w;
      loader_pkg::sram_word_u words [$];
      logic [31:0]            r;
      logic [7:0]             b;
      clk       = 1'b0;
      arst_n    = 1'b0;
      rs_rx     = 1'b1;
      seed      = 32'h82495ea5;
      errors    = 0;
      checks    = 0;
      cycles    = 0;
      dump_left = 0;
      got_idx   = 0;
      r         = $random(seed);
      n_words   = 1 + int'(r % 32'd20);
      // bytes sent plus bytes expected back
      cycle_limit = 12 * loader_pkg::bit_cycles * (80 + 8 * n_words) + 1000;

      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      repeat (2) @(negedge clk);

      // two and a half words, then reset
      send_word(random_word());
      send_word(random_word());
      send_byte(random_byte());
      send_byte(random_byte());
      apply_reset();

      // fresh load from address 0, then the dump
      for (int i = 0; i < n_words; i++) begin
         w = random_word();
         words.push_back(w);
         send_word(w);
      end
      w.word = loader_pkg::end_marker;
      send_word(w);
      foreach (words[i]) begin
         // words past the end of the sram are never stored
         if (i < int'(loader_pkg::sram_words)) begin
            exp_words.push_back(words[i]);
            for (int k = 3; k >= 0; k--) begin
               exp_bytes.push_back(words[i].bytes[k]);
            end
         end
      end
      dump_left = 4 * exp_words.size();
      wait_drained();

      // echo, bytes back to back
      repeat (30) begin
         b = random_byte();
         exp_bytes.push_back(b);
         send_byte(b);
      end
      wait_drained();

      // marker alone, no dump may follow
      apply_reset();
      w.word = loader_pkg::end_marker;
      send_word(w);
      repeat (4 * loader_pkg::bit_cycles) @(negedge clk);
      b = random_byte();
      exp_bytes.push_back(b);
      send_byte(b);
      wait_drained();
      repeat (2 * loader_pkg::bit_cycles) @(negedge clk);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
hw/loader_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/sram_ctrl.sv
hw/loader.sv
hw/top.sv
dv/fake_sram.sv
dv/top_assert.sv
dv/tb_top.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_top
FLIST      = all.f
FLAGS      = --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = *** FAILED ***
PASS_MSG   = *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
